/* fp_dis_top.f */
+incdir+src
src/fp_dis_pkg.sv
src/fp_split_buf.sv
src/fp_dis_ctrl.sv
src/fp_dis_dp.sv
src/fp_gpr.sv
src/fp_wbt.sv
src/fp_dis_top.sv
verification/fp_dis_chk.sv
verification/fp_dis_tb.sv

/* verification/fp_dis_tb.sv */
// FP dispatch testbench
`timescale 1ns/1ps
`default_nettype none

`include "fp_dis_defines.svh"

module fp_dis_tb;

  import fp_dis_pkg::*;

  logic     forever_cpuclk = 1'b0;
  logic     reset;
  logic     inst_vld;
  fp_inst_t inst;
  logic     vex_stall;
  logic     fwd_vld;
  fp_reg_t  fwd_reg;
  fp_data_t fwd_data;
  logic     wb_vld;
  fp_reg_t  wb_reg;
  fp_data_t wb_data;
  logic     flush;
  logic     full;
  logic     no_op;
  logic     issue_vld;
  fp_func_t issue_func;
  logic     issue_dst_vld;
  fp_reg_t  issue_dst_reg;
  fp_data_t issue_src0_data;
  fp_data_t issue_src1_data;
  fp_data_t issue_src2_data;

  // Reference state
  fp_data_t model_regs [`FP_DIS_NUM_REGS];
  fp_pend_t model_pend;
  logic     exp_vld;
  fp_inst_t exp_inst;
  logic     exp_issue;
  integer   seed;
  int       errors = 0;
  int       timeouts = 0;

  always #5 forever_cpuclk = ~forever_cpuclk;

  fp_dis_top dut0 (
    .forever_cpuclk  (forever_cpuclk),
    .reset           (reset),
    .inst_vld        (inst_vld),
    .inst            (inst),
    .vex_stall       (vex_stall),
    .fwd_vld         (fwd_vld),
    .fwd_reg         (fwd_reg),
    .fwd_data        (fwd_data),
    .wb_vld          (wb_vld),
    .wb_reg          (wb_reg),
    .wb_data         (wb_data),
    .flush           (flush),
    .full            (full),
    .no_op           (no_op),
    .issue_vld       (issue_vld),
    .issue_func      (issue_func),
    .issue_dst_vld   (issue_dst_vld),
    .issue_dst_reg   (issue_dst_reg),
    .issue_src0_data (issue_src0_data),
    .issue_src1_data (issue_src1_data),
    .issue_src2_data (issue_src2_data)
  );

  //============================================================
  // Compare tasks
  //============================================================
  task automatic check_data(input fp_data_t act, input fp_data_t exp, input string what);
    if (act !== exp) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, act, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input fp_reg_t act, input fp_reg_t exp, input string what);
    if (act !== exp) begin
      $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, act, exp);
      errors++;
    end
  endtask

  task automatic check_func(input fp_func_t act, input fp_func_t exp, input string what);
    if (act !== exp) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, act, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, act, exp);
      errors++;
    end
  endtask

  //============================================================
  // Reference model
  //============================================================
  function automatic fp_inst_t make_inst(input fp_func_t func, input logic dv,
                                         input fp_reg_t dst, input logic v0,
                                         input fp_reg_t r0, input logic v1,
                                         input fp_reg_t r1, input logic v2,
                                         input fp_reg_t r2);
    fp_inst_t w;
    w = '0;
    w[`FP_DIS_FUNC_LSB +: `FP_DIS_FUNC_W] = func;
    w[`FP_DIS_DST_LSB +: `FP_DIS_REG_W]   = dst;
    w[`FP_DIS_SRC0_LSB +: `FP_DIS_REG_W]  = r0;
    w[`FP_DIS_SRC1_LSB +: `FP_DIS_REG_W]  = r1;
    w[`FP_DIS_SRC2_LSB +: `FP_DIS_REG_W]  = r2;
    w[`FP_DIS_DST_VLD_BIT]  = dv;
    w[`FP_DIS_SRC0_VLD_BIT] = v0;
    w[`FP_DIS_SRC1_VLD_BIT] = v1;
    w[`FP_DIS_SRC2_VLD_BIT] = v2;
    return w;
  endfunction

  function automatic fp_reg_t src_field(input fp_inst_t w, input int i);
    case (i)
      0:       return w[`FP_DIS_SRC0_LSB +: `FP_DIS_REG_W];
      1:       return w[`FP_DIS_SRC1_LSB +: `FP_DIS_REG_W];
      default: return w[`FP_DIS_SRC2_LSB +: `FP_DIS_REG_W];
    endcase
  endfunction

  function automatic logic bypass_hit(input fp_reg_t r);
    return (fwd_vld && fwd_reg == r) || (wb_vld && wb_reg == r);
  endfunction

  // Some used source is pending and no result port carries it
  function automatic logic deps_blocked(input fp_inst_t w);
    fp_reg_t r;
    for (int i = 0; i < 3; i++) begin
      r = src_field(w, i);
      if (w[`FP_DIS_SRC0_VLD_BIT + i] && model_pend[r] && !bypass_hit(r)) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Forward first, then write-back, then the register array
  function automatic fp_data_t ref_operand(input fp_reg_t r);
    if (fwd_vld && fwd_reg == r) begin
      return fwd_data;
    end else if (wb_vld && wb_reg == r) begin
      return wb_data;
    end
    return model_regs[r];
  endfunction

  //============================================================
  // Cycle compare at mid-cycle
  //============================================================
  always @(negedge forever_cpuclk) begin
    if (reset) begin
      exp_vld    = 1'b0;
      model_pend = '0;
    end else begin
      exp_issue = exp_vld && !vex_stall && !deps_blocked(exp_inst);
      check_bit(issue_vld, exp_issue, "issue_vld");
      check_bit(full, exp_vld && !exp_issue, "full");
      check_bit(no_op, !exp_vld && (model_pend == '0), "no_op");
      if (exp_issue && issue_vld) begin
        check_func(issue_func, exp_inst[`FP_DIS_FUNC_LSB +: `FP_DIS_FUNC_W], "issue_func");
        check_bit(issue_dst_vld, exp_inst[`FP_DIS_DST_VLD_BIT], "issue_dst_vld");
        check_reg(issue_dst_reg, exp_inst[`FP_DIS_DST_LSB +: `FP_DIS_REG_W], "issue_dst_reg");
        check_data(issue_src0_data, ref_operand(src_field(exp_inst, 0)), "issue_src0_data");
        check_data(issue_src1_data, ref_operand(src_field(exp_inst, 1)), "issue_src1_data");
        check_data(issue_src2_data, ref_operand(src_field(exp_inst, 2)), "issue_src2_data");
      end
      // State seen after the coming edge
      if (wb_vld) begin
        model_regs[wb_reg] = wb_data;
      end
      if (flush) begin
        model_pend = '0;
      end else begin
        if (wb_vld) model_pend[wb_reg] = 1'b0;
        if (exp_issue && exp_inst[`FP_DIS_DST_VLD_BIT]) begin
          model_pend[exp_inst[`FP_DIS_DST_LSB +: `FP_DIS_REG_W]] = 1'b1;
        end
      end
      if (flush) begin
        exp_vld = 1'b0;
      end else if (inst_vld && (!exp_vld || exp_issue)) begin
        exp_vld  = 1'b1;
        exp_inst = inst;
      end else if (exp_issue) begin
        exp_vld = 1'b0;
      end
    end
  end

  //============================================================
  // Stimulus helpers
  //============================================================
  task automatic next_cycle();
    @(posedge forever_cpuclk);
    #1;
  endtask

  task automatic write_reg(input fp_reg_t r, input fp_data_t d);
    wb_vld  = 1'b1;
    wb_reg  = r;
    wb_data = d;
    next_cycle();
    wb_vld  = 1'b0;
  endtask

  task automatic send_inst(input fp_inst_t w);
    int n;
    n = 0;
    while (full && n < 20) begin
      n++;
      next_cycle();
    end
    if (full) begin
      $display("Timeout: decoder still blocked by full after %0d cycles", n);
      timeouts++;
    end
    inst_vld = 1'b1;
    inst     = w;
    next_cycle();
    inst_vld = 1'b0;
  endtask

  task automatic wait_issue(input int tmo);
    int n;
    n = 0;
    @(negedge forever_cpuclk);
    while (!issue_vld && n < tmo) begin
      n++;
      @(negedge forever_cpuclk);
    end
    if (!issue_vld) begin
      $display("Timeout: no issue within %0d cycles at %0t", tmo, $time);
      timeouts++;
    end
    next_cycle();
  endtask

  task automatic expect_blocked(input int cycles);
    repeat (cycles) begin
      @(negedge forever_cpuclk);
      check_bit(issue_vld, 1'b0, "issue_vld while blocked");
      check_bit(full, 1'b1, "full while blocked");
      next_cycle();
    end
  endtask

  //============================================================
  // Test sequence
  //============================================================
  initial begin
    logic [31:0] rnd;
    fp_inst_t    w;
    seed      = 32'hee68;
    reset     = 1'b1;
    inst_vld  = 1'b0;
    inst      = '0;
    vex_stall = 1'b0;
    fwd_vld   = 1'b0;
    fwd_reg   = '0;
    fwd_data  = '0;
    wb_vld    = 1'b0;
    wb_reg    = '0;
    wb_data   = '0;
    flush     = 1'b0;
    repeat (4) @(posedge forever_cpuclk);
    #1;
    reset = 1'b0;

    // Reset state
    @(negedge forever_cpuclk);
    check_bit(no_op, 1'b1, "no_op after reset");
    check_bit(full, 1'b0, "full after reset");
    check_bit(issue_vld, 1'b0, "issue_vld after reset");
    next_cycle();

    // Register read with nothing pending
    for (int i = 0; i < `FP_DIS_NUM_REGS; i++) begin
      write_reg(fp_reg_t'(i), {$random(seed), $random(seed)});
    end
    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      w = make_inst(rnd[7:0], rnd[8], rnd[13:9], rnd[14], rnd[19:15],
                    rnd[20], rnd[25:21], rnd[26], rnd[31:27]);
      send_inst(w);
      wait_issue(4);
      if (w[`FP_DIS_DST_VLD_BIT]) begin
        write_reg(w[`FP_DIS_DST_LSB +: `FP_DIS_REG_W], {$random(seed), $random(seed)});
      end
    end

    // Dependency stall released by write-back
    send_inst(make_inst(8'h31, 1'b1, 5'd5, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0));
    wait_issue(4);
    send_inst(make_inst(8'h32, 1'b0, 5'd0, 1'b1, 5'd5, 1'b0, 5'd0, 1'b0, 5'd0));
    expect_blocked(3);
    wb_vld  = 1'b1;
    wb_reg  = 5'd5;
    wb_data = 64'h5a5a_0005_c3c3_0005;
    wait_issue(2);
    wb_vld  = 1'b0;

    // Forward beats a write-back to the same register
    send_inst(make_inst(8'h41, 1'b1, 5'd7, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0));
    wait_issue(4);
    send_inst(make_inst(8'h42, 1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd7, 1'b1, 5'd3));
    expect_blocked(2);
    fwd_vld  = 1'b1;
    fwd_reg  = 5'd7;
    fwd_data = 64'h1111_2222_3333_4444;
    wb_vld   = 1'b1;
    wb_reg   = 5'd7;
    wb_data  = 64'h9999_8888_7777_6666;
    wait_issue(1);
    fwd_vld  = 1'b0;
    wb_vld   = 1'b0;

    // Back-pressure from the execution unit
    vex_stall = 1'b1;
    send_inst(make_inst(8'h53, 1'b0, 5'd0, 1'b1, 5'd1, 1'b1, 5'd2, 1'b1, 5'd3));
    expect_blocked(4);
    vex_stall = 1'b0;
    wait_issue(2);

    // Flush drops the entry and the pending set
    send_inst(make_inst(8'h61, 1'b1, 5'd9, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0));
    wait_issue(4);
    send_inst(make_inst(8'h62, 1'b0, 5'd0, 1'b1, 5'd9, 1'b0, 5'd0, 1'b0, 5'd0));
    expect_blocked(2);
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    @(negedge forever_cpuclk);
    check_bit(no_op, 1'b1, "no_op after flush");
    next_cycle();
    send_inst(make_inst(8'h63, 1'b0, 5'd0, 1'b1, 5'd9, 1'b0, 5'd0, 1'b0, 5'd0));
    wait_issue(1);
    repeat (2) next_cycle();

    $display("Finished with %0d value errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/fp_dis_chk.sv */
// FP dispatch assertions
`timescale 1ns/1ps
`default_nettype none

module fp_dis_chk (
  input logic                 forever_cpuclk,
  input logic                 reset,
  input logic                 flush,
  input logic                 inst_vld,
  input logic                 vex_stall,
  input logic                 issue_vld,
  input logic                 full,
  input logic                 no_op,
  input logic                 entry_vld,
  input fp_dis_pkg::fp_inst_t entry_inst
);

  //==========================================================
  // Issue and status rules
  //==========================================================
  a_no_issue_in_stall: assert property (
    @(posedge forever_cpuclk) disable iff (reset)
    vex_stall |-> !issue_vld
  ) else $error("issue_vld high while vex_stall is high");

  // A blocked entry stays put unless retire flushes it
  a_full_holds_entry: assert property (
    @(posedge forever_cpuclk) disable iff (reset)
    (full && !flush) |=> (entry_vld && (entry_inst == $past(entry_inst)))
  ) else $error("held entry changed while full");

  a_idle_not_issuing: assert property (
    @(posedge forever_cpuclk) disable iff (reset)
    !(no_op && issue_vld)
  ) else $error("no_op and issue_vld high together");

  a_flush_to_idle: assert property (
    @(posedge forever_cpuclk) disable iff (reset)
    (flush && !inst_vld) |=> no_op
  ) else $error("no_op not high one cycle after flush");

endmodule

bind fp_dis_top fp_dis_chk u_chk (
  .forever_cpuclk (forever_cpuclk),
  .reset          (reset),
  .flush          (flush),
  .inst_vld       (inst_vld),
  .vex_stall      (vex_stall),
  .issue_vld      (issue_vld),
  .full           (full),
  .no_op          (no_op),
  .entry_vld      (entry_vld),
  .entry_inst     (entry_inst)
);

`default_nettype wire

/* src/fp_dis_top.sv */
// FP dispatch top level
`timescale 1ns/1ps
`default_nettype none

module fp_dis_top (
  input  logic                 forever_cpuclk,
  input  logic                 reset,
  // Decoder
  input  logic                 inst_vld,
  input  fp_dis_pkg::fp_inst_t inst,
  // Execution unit
  input  logic                 vex_stall,
  input  logic                 fwd_vld,
  input  fp_dis_pkg::fp_reg_t  fwd_reg,
  input  fp_dis_pkg::fp_data_t fwd_data,
  input  logic                 wb_vld,
  input  fp_dis_pkg::fp_reg_t  wb_reg,
  input  fp_dis_pkg::fp_data_t wb_data,
  // Retire
  input  logic                 flush,
  // Status
  output logic                 full,
  output logic                 no_op,
  // Issue to the execution unit
  output logic                 issue_vld,
  output fp_dis_pkg::fp_func_t issue_func,
  output logic                 issue_dst_vld,
  output fp_dis_pkg::fp_reg_t  issue_dst_reg,
  output fp_dis_pkg::fp_data_t issue_src0_data,
  output fp_dis_pkg::fp_data_t issue_src1_data,
  output fp_dis_pkg::fp_data_t issue_src2_data
);

  import fp_dis_pkg::*;

  logic          entry_vld;
  fp_inst_t      entry_inst;
  fp_reg_t       src0_reg;
  fp_reg_t       src1_reg;
  fp_reg_t       src2_reg;
  fp_src_flags_t src_vld;
  fp_src_flags_t src_bypass;
  fp_src_flags_t src_pend;
  fp_data_t      src0_rdata;
  fp_data_t      src1_rdata;
  fp_data_t      src2_rdata;
  logic          table_empty;

  //==========================================================
  // Instruction holding buffer
  //==========================================================
  fp_split_buf u_split (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .flush          (flush),
    .inst_vld       (inst_vld),
    .inst           (inst),
    .issue_vld      (issue_vld),
    .entry_vld      (entry_vld),
    .entry_inst     (entry_inst)
  );

  //==========================================================
  // Decode and bypass
  //==========================================================
  fp_dis_dp u_dp (
    .entry_inst (entry_inst),
    .src0_rdata (src0_rdata),
    .src1_rdata (src1_rdata),
    .src2_rdata (src2_rdata),
    .fwd_vld    (fwd_vld),
    .fwd_reg    (fwd_reg),
    .fwd_data   (fwd_data),
    .wb_vld     (wb_vld),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data),
    .src0_reg   (src0_reg),
    .src1_reg   (src1_reg),
    .src2_reg   (src2_reg),
    .src_vld    (src_vld),
    .src_bypass (src_bypass),
    .dst_vld    (issue_dst_vld),
    .dst_reg    (issue_dst_reg),
    .func       (issue_func),
    .src0_data  (issue_src0_data),
    .src1_data  (issue_src1_data),
    .src2_data  (issue_src2_data)
  );

  //==========================================================
  // Register file and write-back table
  //==========================================================
  fp_gpr u_gpr (
    .forever_cpuclk (forever_cpuclk),
    .src0_reg       (src0_reg),
    .src1_reg       (src1_reg),
    .src2_reg       (src2_reg),
    .wb_vld         (wb_vld),
    .wb_reg         (wb_reg),
    .wb_data        (wb_data),
    .src0_rdata     (src0_rdata),
    .src1_rdata     (src1_rdata),
    .src2_rdata     (src2_rdata)
  );

  fp_wbt u_wbt (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .flush          (flush),
    .issue_vld      (issue_vld),
    .dst_vld        (issue_dst_vld),
    .dst_reg        (issue_dst_reg),
    .wb_vld         (wb_vld),
    .wb_reg         (wb_reg),
    .src0_reg       (src0_reg),
    .src1_reg       (src1_reg),
    .src2_reg       (src2_reg),
    .src_pend       (src_pend),
    .table_empty    (table_empty)
  );

  //==========================================================
  // Issue control
  //==========================================================
  fp_dis_ctrl u_ctrl (
    .entry_vld   (entry_vld),
    .vex_stall   (vex_stall),
    .src_vld     (src_vld),
    .src_pend    (src_pend),
    .src_bypass  (src_bypass),
    .table_empty (table_empty),
    .issue_vld   (issue_vld),
    .full        (full),
    .no_op       (no_op)
  );

endmodule

`default_nettype wire

/* src/fp_wbt.sv */
// FP write-back table
`timescale 1ns/1ps
`default_nettype none

module fp_wbt (
  input  logic                      forever_cpuclk,
  input  logic                      reset,
  input  logic                      flush,
  input  logic                      issue_vld,
  input  logic                      dst_vld,
  input  fp_dis_pkg::fp_reg_t       dst_reg,
  input  logic                      wb_vld,
  input  fp_dis_pkg::fp_reg_t       wb_reg,
  input  fp_dis_pkg::fp_reg_t       src0_reg,
  input  fp_dis_pkg::fp_reg_t       src1_reg,
  input  fp_dis_pkg::fp_reg_t       src2_reg,
  output fp_dis_pkg::fp_src_flags_t src_pend,
  output logic                      table_empty
);

  import fp_dis_pkg::*;

  fp_pend_t pend_q;
  fp_pend_t set_mask;
  fp_pend_t clr_mask;

  //==========================================================
  // Update masks
  //==========================================================
  // Issued destination becomes pending
  assign set_mask = (issue_vld && dst_vld) ? (fp_pend_t'(1) << dst_reg) : '0;

  // Returning result releases its register
  assign clr_mask = wb_vld ? (fp_pend_t'(1) << wb_reg) : '0;

  //==========================================================
  // Pending vector
  //==========================================================
  // Set is applied after clear, so a new owner of the
  // same register keeps it pending
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      pend_q <= '0;
    end else if (flush) begin
      pend_q <= '0;
    end else begin
      pend_q <= (pend_q & ~clr_mask) | set_mask;
    end
  end

  //==========================================================
  // Lookup
  //==========================================================
  assign src_pend[0] = pend_q[src0_reg];
  assign src_pend[1] = pend_q[src1_reg];
  assign src_pend[2] = pend_q[src2_reg];

  // Nothing left in flight
  assign table_empty = (pend_q == '0);

endmodule

`default_nettype wire

/* src/fp_gpr.sv */
// FP register file
`timescale 1ns/1ps
`default_nettype none

`include "fp_dis_defines.svh"

module fp_gpr (
  input  logic                 forever_cpuclk,
  input  fp_dis_pkg::fp_reg_t  src0_reg,
  input  fp_dis_pkg::fp_reg_t  src1_reg,
  input  fp_dis_pkg::fp_reg_t  src2_reg,
  input  logic                 wb_vld,
  input  fp_dis_pkg::fp_reg_t  wb_reg,
  input  fp_dis_pkg::fp_data_t wb_data,
  output fp_dis_pkg::fp_data_t src0_rdata,
  output fp_dis_pkg::fp_data_t src1_rdata,
  output fp_dis_pkg::fp_data_t src2_rdata
);

  import fp_dis_pkg::*;

  fp_data_t regs [`FP_DIS_NUM_REGS];

  //==========================================================
  // Write port
  //==========================================================
  // Result lands at the edge, visible to reads one cycle later
  always_ff @(posedge forever_cpuclk) begin
    if (wb_vld) begin
      regs[wb_reg] <= wb_data;
    end
  end

  //==========================================================
  // Read ports
  //==========================================================
  // Asynchronous, no internal write-through
  // Same-cycle write data reaches dispatch through the dp bypass
  assign src0_rdata = regs[src0_reg];
  assign src1_rdata = regs[src1_reg];
  assign src2_rdata = regs[src2_reg];

endmodule

`default_nettype wire

/* src/fp_dis_dp.sv */
// FP dispatch datapath
`timescale 1ns/1ps
`default_nettype none

`include "fp_dis_defines.svh"

module fp_dis_dp (
  input  fp_dis_pkg::fp_inst_t      entry_inst,
  input  fp_dis_pkg::fp_data_t      src0_rdata,
  input  fp_dis_pkg::fp_data_t      src1_rdata,
  input  fp_dis_pkg::fp_data_t      src2_rdata,
  input  logic                      fwd_vld,
  input  fp_dis_pkg::fp_reg_t       fwd_reg,
  input  fp_dis_pkg::fp_data_t      fwd_data,
  input  logic                      wb_vld,
  input  fp_dis_pkg::fp_reg_t       wb_reg,
  input  fp_dis_pkg::fp_data_t      wb_data,
  output fp_dis_pkg::fp_reg_t       src0_reg,
  output fp_dis_pkg::fp_reg_t       src1_reg,
  output fp_dis_pkg::fp_reg_t       src2_reg,
  output fp_dis_pkg::fp_src_flags_t src_vld,
  output fp_dis_pkg::fp_src_flags_t src_bypass,
  output logic                      dst_vld,
  output fp_dis_pkg::fp_reg_t       dst_reg,
  output fp_dis_pkg::fp_func_t      func,
  output fp_dis_pkg::fp_data_t      src0_data,
  output fp_dis_pkg::fp_data_t      src1_data,
  output fp_dis_pkg::fp_data_t      src2_data
);

  import fp_dis_pkg::*;

  fp_reg_t       src_reg [3];
  fp_data_t      rdata   [3];
  fp_data_t      op_data [3];
  fp_src_flags_t fwd_hit;
  fp_src_flags_t wb_hit;

  //==========================================================
  // Field decode
  //==========================================================
  assign func    = entry_inst[`FP_DIS_FUNC_LSB +: `FP_DIS_FUNC_W];
  assign dst_reg = entry_inst[`FP_DIS_DST_LSB +: `FP_DIS_REG_W];
  assign dst_vld = entry_inst[`FP_DIS_DST_VLD_BIT];

  assign src_reg[0] = entry_inst[`FP_DIS_SRC0_LSB +: `FP_DIS_REG_W];
  assign src_reg[1] = entry_inst[`FP_DIS_SRC1_LSB +: `FP_DIS_REG_W];
  assign src_reg[2] = entry_inst[`FP_DIS_SRC2_LSB +: `FP_DIS_REG_W];

  assign src_vld = {entry_inst[`FP_DIS_SRC2_VLD_BIT],
                    entry_inst[`FP_DIS_SRC1_VLD_BIT],
                    entry_inst[`FP_DIS_SRC0_VLD_BIT]};

  assign src0_reg = src_reg[0];
  assign src1_reg = src_reg[1];
  assign src2_reg = src_reg[2];

  assign rdata[0] = src0_rdata;
  assign rdata[1] = src1_rdata;
  assign rdata[2] = src2_rdata;

  //==========================================================
  // Bypass match and operand select
  //==========================================================
  // Forward port is the younger result, so it wins over write-back
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      fwd_hit[i] = fwd_vld && (fwd_reg == src_reg[i]);
      wb_hit[i]  = wb_vld && (wb_reg == src_reg[i]);
      if (fwd_hit[i]) begin
        op_data[i] = fwd_data;
      end else if (wb_hit[i]) begin
        op_data[i] = wb_data;
      end else begin
        op_data[i] = rdata[i];
      end
    end
  end

  assign src_bypass = fwd_hit | wb_hit;

  assign src0_data = op_data[0];
  assign src1_data = op_data[1];
  assign src2_data = op_data[2];

endmodule

`default_nettype wire

/* src/fp_dis_ctrl.sv */
// FP dispatch control
`timescale 1ns/1ps
`default_nettype none

module fp_dis_ctrl (
  input  logic                      entry_vld,
  input  logic                      vex_stall,
  input  fp_dis_pkg::fp_src_flags_t src_vld,
  input  fp_dis_pkg::fp_src_flags_t src_pend,
  input  fp_dis_pkg::fp_src_flags_t src_bypass,
  input  logic                      table_empty,
  output logic                      issue_vld,
  output logic                      full,
  output logic                      no_op
);

  import fp_dis_pkg::*;

  fp_src_flags_t src_wait;
  logic          dep_stall;

  //==========================================================
  // Dependency stall
  //==========================================================
  // A used source still waits when its register is pending
  // and neither result port carries it this cycle
  assign src_wait  = src_vld & src_pend & ~src_bypass;
  assign dep_stall = |src_wait;

  //==========================================================
  // Issue
  //==========================================================
  always_comb begin
    issue_vld = 1'b0;
    if (entry_vld && !vex_stall && !dep_stall) begin
      issue_vld = 1'b1;
    end
  end

  //==========================================================
  // Status
  //==========================================================
  // Back-pressure to the decoder
  // Slot frees up in the same cycle it issues
  assign full = entry_vld && !issue_vld;

  // Idle
  assign no_op = !entry_vld && table_empty;

endmodule

`default_nettype wire

/* src/fp_split_buf.sv */
// FP dispatch split buffer
`timescale 1ns/1ps
`default_nettype none

module fp_split_buf (
  input  logic                 forever_cpuclk,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 inst_vld,
  input  fp_dis_pkg::fp_inst_t inst,
  input  logic                 issue_vld,
  output logic                 entry_vld,
  output fp_dis_pkg::fp_inst_t entry_inst
);

  logic load_en;

  //==========================================================
  // Accept
  //==========================================================
  // Room when the slot is empty or leaves this cycle
  assign load_en = inst_vld && (!entry_vld || issue_vld);

  //==========================================================
  // Entry valid
  //==========================================================
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      entry_vld <= 1'b0;
    end else if (flush) begin
      entry_vld <= 1'b0;
    end else if (load_en) begin
      entry_vld <= 1'b1;
    end else if (issue_vld) begin
      entry_vld <= 1'b0;
    end
  end

  //==========================================================
  // Entry payload
  //==========================================================
  // Word only matters while entry_vld is set
  always_ff @(posedge forever_cpuclk) begin
    if (load_en) begin
      entry_inst <= inst;
    end
  end

endmodule

`default_nettype wire

/* src/fp_dis_pkg.sv */
// FP dispatch types
`default_nettype none

`include "fp_dis_defines.svh"

package fp_dis_pkg;

  //==========================================================
  // Datapath types
  //==========================================================
  // Operand or result
  typedef logic [`FP_DIS_DATA_W-1:0] fp_data_t;

  // Register index
  typedef logic [`FP_DIS_REG_W-1:0] fp_reg_t;

  // Function code handed to the execution unit
  typedef logic [`FP_DIS_FUNC_W-1:0] fp_func_t;

  // Compact instruction word from the decoder
  typedef logic [`FP_DIS_INST_W-1:0] fp_inst_t;

  //==========================================================
  // Control types
  //==========================================================
  // One pending bit per register
  typedef logic [`FP_DIS_NUM_REGS-1:0] fp_pend_t;

  // One flag per source, index 0 to 2
  typedef logic [2:0] fp_src_flags_t;

endpackage

`default_nettype wire

/* src/fp_dis_defines.svh */
// FP dispatch widths and fields
`ifndef FP_DIS_DEFINES_SVH
`define FP_DIS_DEFINES_SVH

//==========================================================
// Widths and register count
//==========================================================
`define FP_DIS_DATA_W       64
`define FP_DIS_REG_W        5
`define FP_DIS_NUM_REGS     32
`define FP_DIS_FUNC_W       8
`define FP_DIS_INST_W       32

//==========================================================
// Instruction word fields
//==========================================================
`define FP_DIS_FUNC_LSB     0
`define FP_DIS_DST_LSB      8
`define FP_DIS_SRC0_LSB     13
`define FP_DIS_SRC1_LSB     18
`define FP_DIS_SRC2_LSB     23

// Valid flags in the top nibble
`define FP_DIS_DST_VLD_BIT  28
`define FP_DIS_SRC0_VLD_BIT 29
`define FP_DIS_SRC1_VLD_BIT 30
`define FP_DIS_SRC2_VLD_BIT 31

`endif
